// ==== rtl/tile_pkg.sv ====
package tile_pkg;

   // Bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int SEL_W  = DATA_W / 8;
   localparam int FLIT_W = 32;

   // Address map, matched against the top address bits
   localparam int DM_RANGE_WIDTH = 1;
   localparam logic [DM_RANGE_WIDTH-1:0] DM_RANGE_MATCH = 1'b0;   // 0x00000000-0x7fffffff
   localparam int NA_RANGE_WIDTH = 4;
   localparam logic [NA_RANGE_WIDTH-1:0] NA_RANGE_MATCH = 4'he;   // 0xe0000000-0xefffffff

   // Data memory
   localparam int DM_WORDS = 1024;
   localparam int DM_AW    = $clog2(DM_WORDS);   // Index taken from adr[DM_AW+1:2]

   // Mailbox
   localparam int NA_FIFO_DEPTH = 4;
   localparam int NA_OFFS_W     = ADDR_W - NA_RANGE_WIDTH;
   localparam logic [NA_OFFS_W-1:0] NA_REG_DATA   = 'h0;
   localparam logic [NA_OFFS_W-1:0] NA_REG_STATUS = 'h4;
   localparam logic [NA_OFFS_W-1:0] NA_REG_LAST   = 'h8;

   typedef struct packed {
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
      logic [SEL_W-1:0]  sel;
      logic              we;
      logic              cyc;
      logic              stb;
   } wb_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] dat;
      logic              ack;
      logic              err;
   } wb_rsp_t;

   typedef struct packed {
      logic [FLIT_W-1:0] data;
      logic              last;   // Closes a packet
   } noc_flit_t;

endpackage

// ==== rtl/flit_fifo.sv ====
module flit_fifo #(
   parameter int DEPTH = tile_pkg::NA_FIFO_DEPTH
) (
   input  logic                clk,
   input  logic                rst_i,

   input  tile_pkg::noc_flit_t in_i,
   input  logic                in_valid_i,
   output logic                in_ready_o,

   output tile_pkg::noc_flit_t out_o,
   output logic                out_valid_o,
   input  logic                out_ready_i
);

   import tile_pkg::*;

   noc_flit_t                  mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]   wr_ptr;
   logic [$clog2(DEPTH)-1:0]   rd_ptr;
   logic [$clog2(DEPTH+1)-1:0] count;
   logic                       push;
   logic                       pop;

   assign in_ready_o  = (int'(count) != DEPTH);
   assign out_valid_o = (count != '0);
   assign out_o       = mem[rd_ptr];   // Head of queue

   assign push = in_valid_i & in_ready_o;
   assign pop  = out_valid_o & out_ready_i;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            if (int'(wr_ptr) == DEPTH - 1) begin
               wr_ptr <= '0;
            end else begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end
         if (pop) begin
            if (int'(rd_ptr) == DEPTH - 1) begin
               rd_ptr <= '0;
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
         // Simultaneous push and pop leaves count alone
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_i;
      end
   end

endmodule

// ==== rtl/dm_ram_slave.sv ====
module dm_ram_slave (
   input  logic              clk,
   input  logic              rst_i,

   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);

   import tile_pkg::*;

   logic [DATA_W-1:0] mem [DM_WORDS];
   logic [DM_AW-1:0]  idx;
   logic              access;
   logic              ack_q;
   logic [DATA_W-1:0] dat_q;

   // Upper address bits are ignored, the memory aliases inside its range
   assign idx    = req_i.adr[DM_AW+1:2];
   assign access = req_i.cyc & req_i.stb & ~ack_q;   // Held stb during ack is ignored

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   // Byte lane writes, read returns the old word
   always_ff @(posedge clk) begin
      if (access) begin
         if (req_i.we) begin
            for (int b = 0; b < SEL_W; b++) begin
               if (req_i.sel[b]) begin
                  mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
               end
            end
         end
         dat_q <= mem[idx];
      end
   end

   assign rsp_o.dat = dat_q;
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;   // Every address in range is backed

endmodule

// ==== rtl/na_mailbox.sv ====
module na_mailbox (
   input  logic                clk,
   input  logic                rst_i,

   input  tile_pkg::wb_req_t   req_i,
   output tile_pkg::wb_rsp_t   rsp_o,

   input  tile_pkg::noc_flit_t noc_in_i,
   input  logic                noc_in_valid_i,
   output logic                noc_in_ready_o,

   output tile_pkg::noc_flit_t noc_out_o,
   output logic                noc_out_valid_o,
   input  logic                noc_out_ready_i,

   output logic                irq_o
);

   import tile_pkg::*;

   logic [NA_OFFS_W-1:0] offs;
   logic                 access;
   logic                 wr_flit;    // Write to DATA or LAST
   logic                 rd_data;    // Read of DATA
   logic                 ok;
   logic [DATA_W-1:0]    rdata;
   noc_flit_t            tx_flit;
   logic                 tx_ready;
   noc_flit_t            rx_head;
   logic                 rx_valid;
   logic                 ack_q;
   logic                 err_q;
   logic [DATA_W-1:0]    dat_q;

   assign offs   = req_i.adr[NA_OFFS_W-1:0];
   assign access = req_i.cyc & req_i.stb & ~ack_q & ~err_q;

   // Register decode and error conditions
   always_comb begin
      wr_flit = 1'b0;
      rd_data = 1'b0;
      ok      = 1'b0;
      rdata   = '0;
      if (req_i.we) begin
         if (offs == NA_REG_DATA || offs == NA_REG_LAST) begin
            wr_flit = 1'b1;
            ok      = tx_ready;   // Full out queue gives err
         end
      end else begin
         if (offs == NA_REG_DATA) begin
            rd_data = 1'b1;
            ok      = rx_valid;
            rdata   = rx_head.data;
         end else if (offs == NA_REG_STATUS) begin
            ok       = 1'b1;
            rdata[0] = rx_valid;
            rdata[1] = ~tx_ready;
            rdata[2] = rx_head.last & rx_valid;
         end
      end
   end

   assign tx_flit.data = req_i.dat;
   assign tx_flit.last = (offs == NA_REG_LAST);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= access & ok;
         err_q <= access & ~ok;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         dat_q <= rdata;
      end
   end

   assign rsp_o.dat = dat_q;
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = err_q;

   // Bus to NoC
   flit_fifo #(
      .DEPTH (NA_FIFO_DEPTH)
   ) u_out_q (
      .clk         (clk),
      .rst_i       (rst_i),
      .in_i        (tx_flit),
      .in_valid_i  (access & wr_flit),   // Queue drops it when full
      .in_ready_o  (tx_ready),
      .out_o       (noc_out_o),
      .out_valid_o (noc_out_valid_o),
      .out_ready_i (noc_out_ready_i)
   );

   // NoC to bus
   flit_fifo #(
      .DEPTH (NA_FIFO_DEPTH)
   ) u_in_q (
      .clk         (clk),
      .rst_i       (rst_i),
      .in_i        (noc_in_i),
      .in_valid_i  (noc_in_valid_i),
      .in_ready_o  (noc_in_ready_o),
      .out_o       (rx_head),
      .out_valid_o (rx_valid),
      .out_ready_i (access & rd_data)    // Pop on DATA read
   );

   assign irq_o = rx_valid;   // Pending received flits

endmodule

// ==== rtl/wb_tile_bus.sv ====
module wb_tile_bus (
   input  logic              clk,
   input  logic              rst_i,

   input  tile_pkg::wb_req_t m_req_i,
   output tile_pkg::wb_rsp_t m_rsp_o,

   output tile_pkg::wb_req_t dm_req_o,
   input  tile_pkg::wb_rsp_t dm_rsp_i,

   output tile_pkg::wb_req_t na_req_o,
   input  tile_pkg::wb_rsp_t na_rsp_i
);

   import tile_pkg::*;

   logic dm_hit;
   logic na_hit;
   logic miss;
   logic err_q;

   // Range match on the upper address bits
   assign dm_hit = (m_req_i.adr[ADDR_W-1 -: DM_RANGE_WIDTH] == DM_RANGE_MATCH);
   assign na_hit = (m_req_i.adr[ADDR_W-1 -: NA_RANGE_WIDTH] == NA_RANGE_MATCH);
   assign miss   = ~dm_hit & ~na_hit;

   // Every slave sees the full request, only the selected one gets stb
   always_comb begin
      dm_req_o     = m_req_i;
      dm_req_o.stb = m_req_i.stb & dm_hit;
      na_req_o     = m_req_i;
      na_req_o.stb = m_req_i.stb & na_hit;
   end

   // Unmapped address answers with err one cycle later
   always_ff @(posedge clk) begin
      if (rst_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= m_req_i.cyc & m_req_i.stb & miss & ~err_q;   // One pulse per request
      end
   end

   // Only the addressed responder can be active, so ack/err merge by OR
   always_comb begin
      m_rsp_o.ack = dm_rsp_i.ack | na_rsp_i.ack;
      m_rsp_o.err = dm_rsp_i.err | na_rsp_i.err | err_q;
      if (dm_rsp_i.ack) begin
         m_rsp_o.dat = dm_rsp_i.dat;
      end else if (na_rsp_i.ack) begin
         m_rsp_o.dat = na_rsp_i.dat;
      end else begin
         m_rsp_o.dat = '0;   // Nothing valid on err
      end
   end

endmodule

// ==== rtl/compute_tile_dm.sv ====
module compute_tile_dm (
   input  logic                clk,
   input  logic                rst_i,

   input  tile_pkg::wb_req_t   wb_req_i,
   output tile_pkg::wb_rsp_t   wb_rsp_o,

   input  tile_pkg::noc_flit_t noc_in_i,
   input  logic                noc_in_valid_i,
   output logic                noc_in_ready_o,

   output tile_pkg::noc_flit_t noc_out_o,
   output logic                noc_out_valid_o,
   input  logic                noc_out_ready_i,

   output logic                irq_o
);

   import tile_pkg::*;

   wb_req_t dm_req;
   wb_rsp_t dm_rsp;
   wb_req_t na_req;
   wb_rsp_t na_rsp;

   wb_tile_bus u_bus (
      .clk      (clk),
      .rst_i    (rst_i),
      .m_req_i  (wb_req_i),
      .m_rsp_o  (wb_rsp_o),
      .dm_req_o (dm_req),
      .dm_rsp_i (dm_rsp),
      .na_req_o (na_req),
      .na_rsp_i (na_rsp)
   );

   dm_ram_slave u_dm (
      .clk   (clk),
      .rst_i (rst_i),
      .req_i (dm_req),
      .rsp_o (dm_rsp)
   );

   na_mailbox u_na (
      .clk             (clk),
      .rst_i           (rst_i),
      .req_i           (na_req),
      .rsp_o           (na_rsp),
      .noc_in_i        (noc_in_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .noc_out_o       (noc_out_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .irq_o           (irq_o)
   );

endmodule

// ==== bench/tb_compute_tile_dm.sv ====
module tb_compute_tile_dm;

   timeunit 1ns;
   timeprecision 1ps;

   import tile_pkg::*;

   localparam int TIMEOUT = 50;   // Cycles allowed per wait
   localparam logic [ADDR_W-1:0] NA_DATA_ADR   = {NA_RANGE_MATCH, NA_REG_DATA};
   localparam logic [ADDR_W-1:0] NA_STATUS_ADR = {NA_RANGE_MATCH, NA_REG_STATUS};
   localparam logic [ADDR_W-1:0] NA_LAST_ADR   = {NA_RANGE_MATCH, NA_REG_LAST};
   localparam logic [ADDR_W-1:0] NA_BAD_ADR    = {NA_RANGE_MATCH, 28'h10};

   // One bus operation of the stimulus table
   typedef struct packed {
      logic              we;
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] wdat;
      logic [SEL_W-1:0]  sel;
      logic [DATA_W-1:0] exp_dat;   // Checked on reads only
      logic              exp_err;
   } bus_op_t;

   logic        clk;
   logic        rst_i;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   noc_flit_t   noc_in;
   logic        noc_in_valid;
   logic        noc_in_ready;
   noc_flit_t   noc_out;
   logic        noc_out_valid;
   logic        noc_out_ready;
   logic        irq;

   bus_op_t     ops[$];
   noc_flit_t   exp_flits[$];   // Flits still owed on noc_out
   integer      seed;
   logic [31:0] rnd;
   logic        rand_ready;
   logic        ready_hold;
   int          checks;
   int          errors;

   compute_tile_dm compute_tile_dm_inst (
      .clk             (clk),
      .rst_i           (rst_i),
      .wb_req_i        (wb_req),
      .wb_rsp_o        (wb_rsp),
      .noc_in_i        (noc_in),
      .noc_in_valid_i  (noc_in_valid),
      .noc_in_ready_o  (noc_in_ready),
      .noc_out_o       (noc_out),
      .noc_out_valid_o (noc_out_valid),
      .noc_out_ready_i (noc_out_ready),
      .irq_o           (irq)
   );

   always #5 clk = ~clk;

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic add_write(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic exp_err);
      bus_op_t op;
      op = '0;
      op.we      = 1'b1;
      op.adr     = adr;
      op.wdat    = dat;
      op.sel     = sel;
      op.exp_err = exp_err;
      ops.push_back(op);
   endtask

   task automatic add_read(input logic [31:0] adr, input logic [31:0] exp_dat,
                           input logic exp_err);
      bus_op_t op;
      op = '0;
      op.adr     = adr;
      op.sel     = 4'hf;
      op.exp_dat = exp_dat;
      op.exp_err = exp_err;
      ops.push_back(op);
   endtask

   // One request, held until ack or err
   task automatic bus_cycle(input bus_op_t op, output wb_rsp_t rsp, output logic done,
                            output int cycles);
      wb_req_t req;
      int      n;
      req     = '0;
      req.adr = op.adr;
      req.dat = op.wdat;
      req.sel = op.sel;
      req.we  = op.we;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      @(posedge clk);
      wb_req <= req;
      done = 1'b0;
      rsp  = '0;
      n    = 0;
      while (!done && n < TIMEOUT) begin
         @(posedge clk);
         n++;
         if (wb_rsp.ack || wb_rsp.err) begin
            done = 1'b1;
            rsp  = wb_rsp;
         end
      end
      cycles = n;
      wb_req <= '0;   // Drop stb in the cycle after the response
      if (!done) begin
         errors++;
         $display("Timeout: no ack or err for address %h at %0t", op.adr, $time);
      end
   endtask

   task automatic run_ops();
      bus_op_t   op;
      wb_rsp_t   rsp;
      noc_flit_t f;
      logic      done;
      int        cycles;
      for (int i = 0; i < ops.size(); i++) begin
         op = ops[i];
         if (op.we && !op.exp_err && (op.adr == NA_DATA_ADR || op.adr == NA_LAST_ADR)) begin
            f.data = op.wdat;
            f.last = (op.adr == NA_LAST_ADR);
            exp_flits.push_back(f);
         end
         bus_cycle(op, rsp, done, cycles);
         if (done) begin
            check("wb_rsp_o latency", cycles, 2);   // Response in the cycle after the request
            check("wb_rsp_o.ack", rsp.ack, !op.exp_err);
            check("wb_rsp_o.err", rsp.err, op.exp_err);
            if (!op.we && !op.exp_err) begin
               check("wb_rsp_o.dat", rsp.dat, op.exp_dat);
            end
            @(posedge clk);
            check("wb_rsp_o.ack", wb_rsp.ack, 1'b0);   // One cycle pulse
            check("wb_rsp_o.err", wb_rsp.err, 1'b0);
         end
      end
      ops.delete();
   endtask

   task automatic wait_out_drained();
      int n;
      n = 0;
      @(posedge clk);
      while (noc_out_valid && n < 4 * TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (noc_out_valid) begin
         errors++;
         $display("Timeout: noc_out still holds flits at %0t", $time);
      end
      check("pending noc_out flits", exp_flits.size(), 0);
   endtask

   task automatic send_flit(input logic [31:0] data, input logic last);
      noc_flit_t f;
      logic      sent;
      int        n;
      f.data = data;
      f.last = last;
      @(posedge clk);
      noc_in       <= f;
      noc_in_valid <= 1'b1;
      sent = 1'b0;
      n    = 0;
      while (!sent && n < TIMEOUT) begin
         @(posedge clk);
         n++;
         sent = noc_in_ready;   // Transfer on this edge
      end
      noc_in_valid <= 1'b0;
      if (!sent) begin
         errors++;
         $display("Timeout: noc_in never accepted flit %h at %0t", data, $time);
      end
   endtask

   // Random or held ready on noc_out
   always @(posedge clk) begin
      rnd = $random(seed);
      if (rand_ready) begin
         noc_out_ready <= rnd[0];
      end else begin
         noc_out_ready <= ready_hold;
      end
   end

   always @(posedge clk) begin : out_monitor
      noc_flit_t f;
      if (!rst_i && noc_out_valid && noc_out_ready) begin
         if (exp_flits.size() == 0) begin
            errors++;
            $display("Unexpected flit %h on noc_out at %0t", noc_out.data, $time);
         end else begin
            f = exp_flits.pop_front();
            check("noc_out_o.data", noc_out.data, f.data);
            check("noc_out_o.last", noc_out.last, f.last);
         end
      end
   end

   initial begin
      clk           = 1'b0;
      rst_i         = 1'b1;
      wb_req        = '0;
      noc_in        = '0;
      noc_in_valid  = 1'b0;
      noc_out_ready = 1'b0;
      seed          = 32'h18e8;
      rand_ready    = 1'b0;
      ready_hold    = 1'b1;
      checks        = 0;
      errors        = 0;
      repeat (3) @(posedge clk);
      rst_i <= 1'b0;

      @(posedge clk);
      check("wb_rsp_o.ack", wb_rsp.ack, 1'b0);
      check("wb_rsp_o.err", wb_rsp.err, 1'b0);
      check("noc_out_valid_o", noc_out_valid, 1'b0);
      check("irq_o", irq, 1'b0);
      check("noc_in_ready_o", noc_in_ready, 1'b1);

      // Byte lanes and aliasing
      add_write(32'h0000_0100, 32'h1122_3344, 4'hf, 1'b0);
      add_write(32'h0000_0100, 32'haabb_ccdd, 4'b0101, 1'b0);
      add_read(32'h0000_0100, 32'h11bb_33dd, 1'b0);
      add_write(32'h0000_0ffc, 32'h0102_0304, 4'hf, 1'b0);
      add_write(32'h0000_0ffc, 32'hcafe_f00d, 4'b1100, 1'b0);
      add_read(32'h7fff_fffc, 32'hcafe_0304, 1'b0);   // Alias of 0xffc
      add_write(32'h0000_0200, 32'h5566_7788, 4'hf, 1'b0);
      add_write(32'h0000_0200, 32'hffff_ffff, 4'b0010, 1'b0);
      add_read(32'h0000_0200, 32'h5566_ff88, 1'b0);
      add_read(32'h1234_5100, 32'h11bb_33dd, 1'b0);   // Alias of 0x100
      // Unmapped space and undefined mailbox offsets
      add_read(32'h9000_0000, 32'h0, 1'b1);
      add_write(32'hf000_0000, 32'hdead_beef, 4'hf, 1'b1);
      add_read(NA_BAD_ADR, 32'h0, 1'b1);
      add_write(NA_STATUS_ADR, 32'h1, 4'hf, 1'b1);
      run_ops();

      // Out path under random back-pressure
      rand_ready <= 1'b1;
      add_write(NA_DATA_ADR, 32'ha000_0001, 4'hf, 1'b0);
      add_write(NA_DATA_ADR, 32'ha000_0002, 4'hf, 1'b0);
      add_write(NA_LAST_ADR, 32'ha000_0003, 4'hf, 1'b0);
      add_write(NA_DATA_ADR, 32'ha000_0004, 4'hf, 1'b0);
      run_ops();
      wait_out_drained();
      add_write(NA_LAST_ADR, 32'ha000_0005, 4'hf, 1'b0);
      add_write(NA_DATA_ADR, 32'ha000_0006, 4'hf, 1'b0);
      add_write(NA_LAST_ADR, 32'ha000_0007, 4'hf, 1'b0);
      run_ops();
      wait_out_drained();

      // Ready held low until the out queue is full
      rand_ready <= 1'b0;
      ready_hold <= 1'b0;
      add_write(NA_DATA_ADR, 32'hc000_0001, 4'hf, 1'b0);
      add_write(NA_LAST_ADR, 32'hc000_0002, 4'hf, 1'b0);
      add_write(NA_DATA_ADR, 32'hc000_0003, 4'hf, 1'b0);
      add_write(NA_LAST_ADR, 32'hc000_0004, 4'hf, 1'b0);
      add_write(NA_DATA_ADR, 32'hc000_0005, 4'hf, 1'b1);   // Queue full
      add_read(NA_STATUS_ADR, 32'h0000_0002, 1'b0);
      run_ops();
      ready_hold <= 1'b1;
      wait_out_drained();

      // Receive path fills the in queue
      send_flit(32'hb000_0001, 1'b0);
      send_flit(32'hb000_0002, 1'b1);
      send_flit(32'hb000_0003, 1'b0);
      send_flit(32'hb000_0004, 1'b1);
      @(posedge clk);
      check("irq_o", irq, 1'b1);
      check("noc_in_ready_o", noc_in_ready, 1'b0);
      add_read(NA_STATUS_ADR, 32'h0000_0001, 1'b0);
      add_read(NA_DATA_ADR, 32'hb000_0001, 1'b0);
      add_read(NA_STATUS_ADR, 32'h0000_0005, 1'b0);   // Head closes a packet
      add_read(NA_DATA_ADR, 32'hb000_0002, 1'b0);
      add_read(NA_STATUS_ADR, 32'h0000_0001, 1'b0);
      add_read(NA_DATA_ADR, 32'hb000_0003, 1'b0);
      add_read(NA_STATUS_ADR, 32'h0000_0005, 1'b0);
      add_read(NA_DATA_ADR, 32'hb000_0004, 1'b0);
      add_read(NA_STATUS_ADR, 32'h0000_0000, 1'b0);
      add_read(NA_DATA_ADR, 32'h0, 1'b1);   // Empty queue
      run_ops();
      @(posedge clk);
      check("irq_o", irq, 1'b0);
      check("noc_in_ready_o", noc_in_ready, 1'b1);

      $display("Checks: %0d  Errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== dm_tile_bus.f ====
rtl/tile_pkg.sv
rtl/flit_fifo.sv
rtl/dm_ram_slave.sv
rtl/na_mailbox.sv
rtl/wb_tile_bus.sv
rtl/compute_tile_dm.sv
bench/tb_compute_tile_dm.sv

// ==== Bender.yml ====
package:
  name: dm_tile_bus

sources:
  - rtl/tile_pkg.sv
  - rtl/flit_fifo.sv
  - rtl/dm_ram_slave.sv
  - rtl/na_mailbox.sv
  - rtl/wb_tile_bus.sv
  - rtl/compute_tile_dm.sv
  - target: simulation
    files:
      - bench/tb_compute_tile_dm.sv
